//--- sweep_pkg.sv
package sweep_pkg;

	// phases of one sweep step
	// the byte pair repeats once per report slot
	typedef enum logic [3:0] {
		start_write,
		wait_write,
		align_reads,
		wait_align,
		test,
		send_byte,
		wait_byte,
		cycle_freq,
		wait_freq,
		finish
	} phase_t;

	// phase counter, wide enough for long test windows
	typedef logic [29:0] cycle_count_t;

	// default timing in CLOCK_50 cycles

	// time for the RAM controller to write the pattern
	localparam cycle_count_t DEF_WRITE_WAIT = 30'd2048;

	// settle time after the read clocks are realigned
	localparam cycle_count_t DEF_ALIGN_WAIT = 30'd2048;

	// length of the error counting window
	localparam cycle_count_t DEF_TEST_CYCLES = 30'd16384;

	// one byte at 115200 baud takes about 4340 cycles
	// so this leaves plenty of margin for the serializer
	localparam cycle_count_t DEF_BYTE_GAP = 30'd10000;

endpackage

//--- report_pkg.sv
package report_pkg;

	// frequency code from the clock source
	typedef logic [8:0] freq_t;

	// error count of one read path
	typedef logic [14:0] path_count_t;

	// sum of both read paths
	typedef logic [15:0] tally_t;

	// one byte toward the serial transmitter
	typedef logic [7:0] report_byte_t;

	// segment pattern, bit 0 is segment a, active low
	typedef logic [6:0] seg_t;

	// index of a report byte
	typedef logic [1:0] slot_t;

	localparam slot_t SLOT_MARKER = 2'd0;
	localparam slot_t SLOT_LOW = 2'd1;
	localparam slot_t SLOT_MID = 2'd2;
	localparam slot_t SLOT_HIGH = 2'd3;

	// first byte of every report, never a data byte
	localparam report_byte_t REPORT_MARKER = 8'h00;

	// top two bits of each data byte
	localparam logic [1:0] DATA_TAG = 2'b01;

	// hex digit to segments
	localparam seg_t seg_code [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30,
		7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03,
		7'h46, 7'h21, 7'h06, 7'h0E
	};

endpackage

//--- sweep_sequencer.sv
`timescale 1ns/1ns

module sweep_sequencer #(
	parameter sweep_pkg::cycle_count_t write_wait = sweep_pkg::DEF_WRITE_WAIT,
	parameter sweep_pkg::cycle_count_t align_wait = sweep_pkg::DEF_ALIGN_WAIT,
	parameter sweep_pkg::cycle_count_t test_cycles = sweep_pkg::DEF_TEST_CYCLES,
	parameter sweep_pkg::cycle_count_t byte_gap = sweep_pkg::DEF_BYTE_GAP,
	parameter report_pkg::freq_t freq_limit = 9'd500
) (
	input  logic              CLOCK_50,
	input  logic              reset_counter,
	input  report_pkg::freq_t frequency,
	input  logic              freq_ready,
	output logic              ram_reset,
	output logic              write_mem,
	output logic              align,
	output logic              next_frequency,
	output logic              test_window,
	output logic              clear_tally,
	output logic              report_strobe,
	output report_pkg::slot_t report_slot,
	output logic              sweep_done
);
	import sweep_pkg::*;
	import report_pkg::*;

	// last counter value of each timed phase
	localparam cycle_count_t write_last = write_wait - cycle_count_t'(1);
	localparam cycle_count_t align_last = align_wait - cycle_count_t'(1);
	localparam cycle_count_t test_last = test_cycles - cycle_count_t'(1);
	// the strobe cycle counts as part of the gap
	localparam cycle_count_t gap_last = byte_gap - cycle_count_t'(2);

	phase_t phase;
	phase_t next_phase;
	cycle_count_t count;
	cycle_count_t next_count;
	logic armed;

	always_comb begin
		next_phase = phase;
		case (phase)
			start_write: begin
				// hold one clock after reset so the strobes get registered
				if (armed)
					next_phase = wait_write;
			end
			wait_write: begin
				if (count == write_last)
					next_phase = align_reads;
			end
			align_reads: begin
				next_phase = wait_align;
			end
			wait_align: begin
				if (count == align_last)
					next_phase = test;
			end
			test: begin
				if (count == test_last)
					next_phase = send_byte;
			end
			send_byte: begin
				next_phase = wait_byte;
			end
			wait_byte: begin
				if (count == gap_last) begin
					if (report_slot != SLOT_HIGH)
						next_phase = send_byte;
					else if (frequency >= freq_limit)
						next_phase = finish;
					else
						next_phase = cycle_freq;
				end
			end
			cycle_freq: begin
				next_phase = wait_freq;
			end
			wait_freq: begin
				// no timeout, the clock source always comes back
				if (freq_ready)
					next_phase = align_reads;
			end
			finish: begin
				next_phase = finish;
			end
			default: begin
				next_phase = start_write;
			end
		endcase
	end

	// counter restarts on every phase change
	assign next_count = (next_phase != phase) ? '0 : count + cycle_count_t'(1);

	always_ff @(posedge CLOCK_50 or posedge reset_counter) begin
		if (reset_counter) begin
			phase <= start_write;
			count <= '0;
			armed <= 1'b0;
			report_slot <= SLOT_MARKER;
			ram_reset <= 1'b0;
			write_mem <= 1'b0;
			align <= 1'b0;
			next_frequency <= 1'b0;
			test_window <= 1'b0;
			clear_tally <= 1'b0;
			report_strobe <= 1'b0;
			sweep_done <= 1'b0;
		end else begin
			phase <= next_phase;
			count <= next_count;
			armed <= 1'b1;
			// step to the next byte, wraps to the marker after the last one
			if (phase == wait_byte && next_phase != wait_byte)
				report_slot <= slot_t'(report_slot + slot_t'(1));
			// outputs follow the phase that is being entered
			ram_reset <= (next_phase == start_write);
			write_mem <= (next_phase == start_write);
			align <= (next_phase == align_reads);
			next_frequency <= (next_phase == cycle_freq);
			test_window <= (next_phase == test);
			clear_tally <= (next_phase == wait_align) && (next_count == align_last);
			report_strobe <= (next_phase == send_byte);
			sweep_done <= (next_phase == finish);
		end
	end

	// the RAM and the clock source never get two commands at once
	a_one_command: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		$onehot0({write_mem, align, next_frequency}));

	// every report byte is a single strobe
	a_single_strobe: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		report_strobe |=> !report_strobe);

endmodule

//--- error_tally.sv
`timescale 1ns/1ns

module error_tally (
	input  logic               CLOCK_50,
	input  logic               reset_counter,
	input  logic               error_1,
	input  logic               error_2,
	input  logic               test_window,
	input  logic               clear_tally,
	input  report_pkg::freq_t  frequency,
	output report_pkg::tally_t total_errors,
	output report_pkg::freq_t  first_fail_freq
);
	import report_pkg::*;

	path_count_t path_count [2];
	logic [1:0] path_error;
	logic fail_seen;

	// index 0 is the even read path, index 1 the odd one
	assign path_error = {error_2, error_1};

	always_ff @(posedge CLOCK_50 or posedge reset_counter) begin
		if (reset_counter) begin
			for (int i = 0; i < 2; i++)
				path_count[i] <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (clear_tally)
					path_count[i] <= '0;
				else if (test_window && path_error[i])
					path_count[i] <= path_count[i] + path_count_t'(1);
			end
		end
	end

	// 16 bits cannot overflow with two 15 bit counters
	assign total_errors = tally_t'(path_count[0]) + tally_t'(path_count[1]);

	// first failure over the whole sweep, kept until reset
	always_ff @(posedge CLOCK_50 or posedge reset_counter) begin
		if (reset_counter) begin
			fail_seen <= 1'b0;
			first_fail_freq <= '0;
		end else if (test_window && (|path_error) && !fail_seen) begin
			fail_seen <= 1'b1;
			first_fail_freq <= frequency;
		end
	end

	// counts only move inside the test window or on a clear
	a_hold_outside_window: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(!test_window && !clear_tally)
		|=> ($stable(path_count[0]) && $stable(path_count[1])));

endmodule

//--- report_formatter.sv
`timescale 1ns/1ns

module report_formatter (
	input  logic                     CLOCK_50,
	input  logic                     reset_counter,
	input  logic                     report_strobe,
	input  report_pkg::slot_t        report_slot,
	input  report_pkg::tally_t       total_errors,
	input  report_pkg::freq_t        frequency,
	input  report_pkg::freq_t        first_fail_freq,
	output report_pkg::report_byte_t uart_data,
	output logic                     uart_send,
	output report_pkg::seg_t         hex0,
	output report_pkg::seg_t         hex1,
	output report_pkg::seg_t         hex2,
	output report_pkg::seg_t         hex3,
	output report_pkg::seg_t         hex4,
	output report_pkg::seg_t         hex5
);
	import report_pkg::*;

	report_byte_t slot_byte;

	// six bits of the total per data byte, low bits first
	always_comb begin
		case (report_slot)
			SLOT_MARKER: begin
				slot_byte = REPORT_MARKER;
			end
			SLOT_LOW: begin
				slot_byte = {DATA_TAG, total_errors[5:0]};
			end
			SLOT_MID: begin
				slot_byte = {DATA_TAG, total_errors[11:6]};
			end
			SLOT_HIGH: begin
				slot_byte = {DATA_TAG, 2'b00, total_errors[15:12]};
			end
			default: begin
				slot_byte = REPORT_MARKER;
			end
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset_counter) begin
		if (reset_counter)
			uart_send <= 1'b0;
		else
			uart_send <= report_strobe;
	end

	// byte stays put between strobes while the serializer shifts it out
	always_ff @(posedge CLOCK_50) begin
		if (report_strobe)
			uart_data <= slot_byte;
	end

	// current frequency on the right, first failing one on the left
	// top digit of each group only shows bit 8
	always_ff @(posedge CLOCK_50) begin
		hex0 <= seg_code[frequency[3:0]];
		hex1 <= seg_code[frequency[7:4]];
		hex2 <= seg_code[{3'b000, frequency[8]}];
		hex3 <= seg_code[first_fail_freq[3:0]];
		hex4 <= seg_code[first_fail_freq[7:4]];
		hex5 <= seg_code[{3'b000, first_fail_freq[8]}];
	end

endmodule

//--- sweep_tester.sv
`timescale 1ns/1ns

module sweep_tester #(
	parameter sweep_pkg::cycle_count_t write_wait = sweep_pkg::DEF_WRITE_WAIT,
	parameter sweep_pkg::cycle_count_t align_wait = sweep_pkg::DEF_ALIGN_WAIT,
	parameter sweep_pkg::cycle_count_t test_cycles = sweep_pkg::DEF_TEST_CYCLES,
	parameter sweep_pkg::cycle_count_t byte_gap = sweep_pkg::DEF_BYTE_GAP,
	parameter report_pkg::freq_t freq_limit = 9'd500
) (
	input  logic                     CLOCK_50,
	input  logic                     reset_counter,
	input  report_pkg::freq_t        frequency,
	input  logic                     freq_ready,
	input  logic                     error_1,
	input  logic                     error_2,
	output logic                     ram_reset,
	output logic                     write_mem,
	output logic                     align,
	output logic                     next_frequency,
	output report_pkg::report_byte_t uart_data,
	output logic                     uart_send,
	output report_pkg::seg_t         hex0,
	output report_pkg::seg_t         hex1,
	output report_pkg::seg_t         hex2,
	output report_pkg::seg_t         hex3,
	output report_pkg::seg_t         hex4,
	output report_pkg::seg_t         hex5,
	output logic                     sweep_done
);
	import report_pkg::*;

	logic test_window;
	logic clear_tally;
	logic report_strobe;
	slot_t report_slot;
	tally_t total_errors;
	freq_t first_fail_freq;

	sweep_sequencer #(
		.write_wait(write_wait),
		.align_wait(align_wait),
		.test_cycles(test_cycles),
		.byte_gap(byte_gap),
		.freq_limit(freq_limit)
	) i_sweep_sequencer (
		.CLOCK_50(CLOCK_50),
		.reset_counter(reset_counter),
		.frequency(frequency),
		.freq_ready(freq_ready),
		.ram_reset(ram_reset),
		.write_mem(write_mem),
		.align(align),
		.next_frequency(next_frequency),
		.test_window(test_window),
		.clear_tally(clear_tally),
		.report_strobe(report_strobe),
		.report_slot(report_slot),
		.sweep_done(sweep_done)
	);

	error_tally i_error_tally (
		.CLOCK_50(CLOCK_50),
		.reset_counter(reset_counter),
		.error_1(error_1),
		.error_2(error_2),
		.test_window(test_window),
		.clear_tally(clear_tally),
		.frequency(frequency),
		.total_errors(total_errors),
		.first_fail_freq(first_fail_freq)
	);

	report_formatter i_report_formatter (
		.CLOCK_50(CLOCK_50),
		.reset_counter(reset_counter),
		.report_strobe(report_strobe),
		.report_slot(report_slot),
		.total_errors(total_errors),
		.frequency(frequency),
		.first_fail_freq(first_fail_freq),
		.uart_data(uart_data),
		.uart_send(uart_send),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

endmodule

//--- tb_sweep_tester.sv
`timescale 1ns/1ns

module tb_sweep_tester;
	import sweep_pkg::*;
	import report_pkg::*;

	// short timing so the whole sweep runs in a few thousand cycles
	localparam cycle_count_t write_wait = 30'd20;
	localparam cycle_count_t align_wait = 30'd20;
	localparam cycle_count_t test_cycles = 30'd50;
	localparam cycle_count_t byte_gap = 30'd12;
	localparam freq_t freq_limit = 9'd40;
	localparam freq_t freq_first = 9'd4;
	localparam freq_t freq_step = 9'd4;
	localparam int num_steps = int'(freq_limit - freq_first) / int'(freq_step) + 1;
	// align, window, four bytes, worst ready delay and a little slack
	localparam int step_length = int'(align_wait) + int'(test_cycles) + 4 * int'(byte_gap) + 12;
	localparam int run_limit = 5 + int'(write_wait) + num_steps * step_length + 200;

	logic CLOCK_50;
	logic reset_counter;
	freq_t frequency;
	logic freq_ready;
	logic error_1;
	logic error_2;
	logic ram_reset;
	logic write_mem;
	logic align;
	logic next_frequency;
	report_byte_t uart_data;
	logic uart_send;
	seg_t hex0, hex1, hex2, hex3, hex4, hex5;
	logic sweep_done;

	freq_t fail_thr;
	freq_t freq_q;
	freq_t expected_first_fail;
	tally_t expected_total;
	int ready_delay;
	logic step_pulse;
	logic step_wait;
	int sends_in_step;
	logic [5:0] low_bits;
	logic [5:0] mid_bits;
	logic [5:0] controls;
	int failures [5] = '{0, 0, 0, 0, 0};
	int reset_checks = 0;
	int write_pulses = 0;
	int step_aligns = 0;
	int bytes_seen = 0;
	int hex_checks = 0;
	int done_cycles = 0;
	int cycle_count = 0;

	assign controls = {ram_reset, write_mem, align, next_frequency, uart_send, sweep_done};

	sweep_tester #(
		.write_wait(write_wait),
		.align_wait(align_wait),
		.test_cycles(test_cycles),
		.byte_gap(byte_gap),
		.freq_limit(freq_limit)
	) i_sweep_tester (
		.CLOCK_50(CLOCK_50),
		.reset_counter(reset_counter),
		.frequency(frequency),
		.freq_ready(freq_ready),
		.error_1(error_1),
		.error_2(error_2),
		.ram_reset(ram_reset),
		.write_mem(write_mem),
		.align(align),
		.next_frequency(next_frequency),
		.uart_data(uart_data),
		.uart_send(uart_send),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.sweep_done(sweep_done)
	);

	always #4 CLOCK_50 = ~CLOCK_50;

	// errors counted per window: one path at the threshold, both 8 above it
	function automatic tally_t total_for(input freq_t f);
		int paths;
		paths = 0;
		if (f >= fail_thr)
			paths = paths + 1;
		if (f >= fail_thr + freq_t'(8))
			paths = paths + 1;
		return tally_t'(paths * int'(test_cycles));
	endfunction

	// three digits, low nibble first, top digit is bit 8 only
	function automatic logic [20:0] segments_for(input freq_t f);
		logic [3:0] top;
		top = {3'b000, f[8]};
		return {seg_code[top], seg_code[f[7:4]], seg_code[f[3:0]]};
	endfunction

	task automatic record_failure(input int test_index);
		failures[test_index] = failures[test_index] + 1;
	endtask

	task automatic print_test_line(input int test_index, input string name, input int checks);
		$display("test %0d %s: %0d checks, %0d failures", test_index + 1, name, checks,
			failures[test_index]);
	endtask

	// frequency source model, steps on each pulse and locks after a random delay
	always @(posedge CLOCK_50) begin
		step_pulse = next_frequency;
		#1;
		if (step_pulse) begin
			frequency = frequency + freq_step;
			freq_ready = 1'b0;
			ready_delay = 1 + int'($urandom % 8);
			error_1 = (frequency >= fail_thr);
			error_2 = (frequency >= fail_thr + freq_t'(8));
			expected_total = total_for(frequency);
			if (expected_first_fail == '0 && frequency >= fail_thr)
				expected_first_fail = frequency;
		end else if (!freq_ready) begin
			ready_delay = ready_delay - 1;
			if (ready_delay == 0)
				freq_ready = 1'b1;
		end
	end

	// step tracking for the checks
	always @(posedge CLOCK_50 or posedge reset_counter) begin
		if (reset_counter) begin
			step_wait <= 1'b0;
			sends_in_step <= 0;
			low_bits <= '0;
			mid_bits <= '0;
		end else begin
			if (next_frequency)
				step_wait <= 1'b1;
			else if (align)
				step_wait <= 1'b0;
			if (next_frequency)
				sends_in_step <= 0;
			else if (uart_send)
				sends_in_step <= sends_in_step + 1;
			if (uart_send && sends_in_step == 1)
				low_bits <= uart_data[5:0];
			if (uart_send && sends_in_step == 2)
				mid_bits <= uart_data[5:0];
		end
	end

	always @(posedge CLOCK_50) begin
		freq_q <= frequency;
		if (reset_counter)
			reset_checks <= reset_checks + 1;
		else
			hex_checks <= hex_checks + 1;
		if (write_mem)
			write_pulses <= write_pulses + 1;
		if (step_wait && align)
			step_aligns <= step_aligns + 1;
		if (uart_send)
			bytes_seen <= bytes_seen + 1;
		if (sweep_done)
			done_cycles <= done_cycles + 1;
	end

	// run limit
	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= run_limit) begin
			$display("timeout: sweep not finished after %0d cycles", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// reset and the pattern write
	a_quiet_reset: assert property (@(posedge CLOCK_50)
		($past(reset_counter)) |-> controls == '0)
		else begin
			$display("[FAIL] reset_and_write: expected controls 000000, actual %b",
				$sampled(controls));
			record_failure(0);
		end
	a_write_first: assert property (@(posedge CLOCK_50)
		(!reset_counter && $past(reset_counter)) |=> (ram_reset && write_mem))
		else begin
			$display("[FAIL] reset_and_write: expected ram_reset and write_mem 11, actual %b%b",
				$sampled(ram_reset), $sampled(write_mem));
			record_failure(0);
		end
	// only the first cycle after reset may carry the RAM reset and the write
	a_write_ram_reset: assert property (@(posedge CLOCK_50)
		!(!$past(reset_counter) && $past(reset_counter, 2)) |-> (!ram_reset && !write_mem))
		else begin
			$display("[FAIL] reset_and_write: expected ram_reset and write_mem 00, actual %b%b",
				$sampled(ram_reset), $sampled(write_mem));
			record_failure(0);
		end

	// align waits for the frequency source
	a_align_held: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(next_frequency || (step_wait && !freq_ready)) |=> !align)
		else begin
			$display("[FAIL] align_after_step: expected align 0, actual 1");
			record_failure(1);
		end
	a_align_rise: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(step_wait && freq_ready && !align) |=> align)
		else begin
			$display("[FAIL] align_after_step: expected align 1, actual 0");
			record_failure(1);
		end

	// report bytes
	a_marker: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(uart_send && sends_in_step == 0) |-> uart_data == 8'h00)
		else begin
			$display("[FAIL] report_bytes: expected marker 00, actual %h", $sampled(uart_data));
			record_failure(2);
		end
	a_data_tag: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(uart_send && sends_in_step != 0) |-> uart_data[7:6] == 2'b01)
		else begin
			$display("[FAIL] report_bytes: expected tag 01, actual %b", $sampled(uart_data[7:6]));
			record_failure(2);
		end
	a_total: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(uart_send && sends_in_step == 3)
		|-> (uart_data[5:4] == 2'b00 && {uart_data[3:0], mid_bits, low_bits} == expected_total))
		else begin
			$display("[FAIL] report_bytes: expected total %0d, actual %0d (byte %h)",
				$sampled(expected_total),
				$sampled({uart_data[3:0], mid_bits, low_bits}), $sampled(uart_data));
			record_failure(2);
		end
	a_four_bytes: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		(next_frequency || $rose(sweep_done)) |-> sends_in_step == 4)
		else begin
			$display("[FAIL] report_bytes: expected 4 bytes in step, actual %0d",
				$sampled(sends_in_step));
			record_failure(2);
		end

	// seven-segment digits
	a_hex_current: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		{hex2, hex1, hex0} == segments_for(freq_q))
		else begin
			$display("[FAIL] hex_display: expected %h, actual %h",
				$sampled(segments_for(freq_q)), $sampled({hex2, hex1, hex0}));
			record_failure(3);
		end
	a_hex_first_fail: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		uart_send |-> {hex5, hex4, hex3} == segments_for(expected_first_fail))
		else begin
			$display("[FAIL] hex_display: expected %h, actual %h",
				$sampled(segments_for(expected_first_fail)), $sampled({hex5, hex4, hex3}));
			record_failure(3);
		end

	// end of the sweep
	a_done_freq: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		sweep_done |-> frequency == freq_limit)
		else begin
			$display("[FAIL] sweep_end: expected frequency %0d, actual %0d",
				freq_limit, $sampled(frequency));
			record_failure(4);
		end
	a_done_quiet: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		sweep_done |-> !(next_frequency || align || uart_send))
		else begin
			$display("sweep_end: a pulse came out after the sweep finished");
			record_failure(4);
		end
	a_done_held: assert property (@(posedge CLOCK_50) disable iff (reset_counter)
		sweep_done |=> sweep_done)
		else begin
			$display("sweep_end: sweep_done dropped after the sweep finished");
			record_failure(4);
		end

	task automatic finish_run();
		int total_checks;
		int total_failures;
		assert (write_pulses == 1) else begin
			$display("[FAIL] reset_and_write: expected 1 write pulse, actual %0d", write_pulses);
			record_failure(0);
		end
		assert (step_aligns == num_steps - 1) else begin
			$display("[FAIL] align_after_step: expected %0d aligns, actual %0d",
				num_steps - 1, step_aligns);
			record_failure(1);
		end
		assert (bytes_seen == 4 * num_steps) else begin
			$display("[FAIL] report_bytes: expected %0d bytes, actual %0d",
				4 * num_steps, bytes_seen);
			record_failure(2);
		end
		print_test_line(0, "reset_and_write", reset_checks + write_pulses);
		print_test_line(1, "align_after_step", step_aligns);
		print_test_line(2, "report_bytes", bytes_seen);
		print_test_line(3, "hex_display", hex_checks);
		print_test_line(4, "sweep_end", done_cycles);
		total_checks = reset_checks + write_pulses + step_aligns + bytes_seen + hex_checks
			+ done_cycles;
		total_failures = failures[0] + failures[1] + failures[2] + failures[3] + failures[4];
		$display("checks: %0d, failures: %0d", total_checks, total_failures);
		if (total_failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
	endtask

	initial begin
		CLOCK_50 = 1'b0;
		reset_counter = 1'b1;
		frequency = freq_first;
		freq_ready = 1'b1;
		error_1 = 1'b0;
		error_2 = 1'b0;
		ready_delay = 0;
		step_pulse = 1'b0;
		expected_first_fail = '0;
		void'($urandom(32'he089));
		fail_thr = freq_t'(12 + $urandom % 19);
		expected_total = total_for(frequency);
		$display("fail threshold %0d, %0d steps", fail_thr, num_steps);
		repeat (5) @(posedge CLOCK_50);
		#1;
		reset_counter = 1'b0;
		wait (sweep_done);
		// give the post-finish checks some cycles
		repeat (40) @(posedge CLOCK_50);
		#1;
		finish_run();
		$finish;
	end

endmodule

//--- flist.f
sweep_pkg.sv
report_pkg.sv
sweep_sequencer.sv
error_tally.sv
report_formatter.sv
sweep_tester.sv
tb_sweep_tester.sv

//--- Makefile
# Verilator build and run for the sweep tester

VERILATOR ?= verilator
TOP ?= tb_sweep_tester
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns
PASS_TEXT ?= === PASS ===

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(SIM))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
